// ==== lsu_pkg.sv ====
package lsu_pkg;

  // named widths used across the memory stage
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;     // one enable per byte lane
  typedef logic [4:0]  reg_idx_t;

  // memory operation carried by each request
  typedef enum logic [3:0] {
    op_none = 4'd0,  // pass-through of the alu result to rd
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } mem_op_e;

  // 105-bit request from the execute stage
  typedef struct packed {
    mem_op_e  op;
    addr_t    addr;        // byte address
    word_t    wdata;       // sb and sh take only the low bits
    reg_idx_t rd;
    word_t    alu_result;  // returned for op_none
  } lsu_req_t;

  // 38-bit writeback response
  typedef struct packed {
    reg_idx_t rd;
    logic     rd_we;
    word_t    rd_data;
  } lsu_resp_t;

  // 68-bit command to the data memory
  typedef struct packed {
    addr_t addr;   // always word aligned
    strb_t wstrb;  // all zero for reads
    word_t wdata;  // already replicated into the strobed lanes
  } mem_cmd_t;

endpackage

// ==== lsu_flow_pkg.sv ====
package lsu_flow_pkg;

  // credit counters and fifo occupancy share this width
  typedef logic [3:0] credit_t;

  // largest count a credit_t holds
  // buffer depths and credit grants must stay at or below it
  localparam int unsigned max_credits = 15;

endpackage

// ==== lsu_req_buffer.sv ====
module lsu_req_buffer #(
  parameter int unsigned DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  input  logic              pop,
  output lsu_pkg::lsu_req_t head,
  output logic              head_valid,
  output logic              req_credit
);
  import lsu_pkg::*;
  import lsu_flow_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  lsu_req_t entries [DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  credit_t  count;   // entries held

  // circular pointer step, depth need not be a power of two
  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? ptr_t'(0) : ptr_t'(p + 1'b1);
  endfunction

  if (DEPTH < 1 || DEPTH > max_credits) begin : g_depth_check
    $error("request buffer depth %0d out of range", DEPTH);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      if (req_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or write and pop together
      endcase
      req_credit <= pop;  // entry freed, hand its credit back
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (req_valid)
      entries[wr_ptr] <= req;
  end

  assign head       = entries[rd_ptr];
  assign head_valid = (count != '0);

  // sender spends a credit per request, so a full buffer never sees one
  req_no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    req_valid |-> (count < DEPTH)
  ) else $error("request written into a full buffer");

  // accessor pops only what is there
  req_no_underflow: assert property (
    @(posedge clk) disable iff (reset)
    pop |-> head_valid
  ) else $error("pop from an empty request buffer");

endmodule

// ==== lsu_accessor.sv ====
module lsu_accessor (
  input  logic               clk,
  input  logic               reset,
  input  lsu_pkg::lsu_req_t  head,
  input  logic               head_valid,
  input  logic               out_space,
  input  lsu_pkg::word_t     mem_rdata,
  output logic               pop,
  output lsu_pkg::mem_cmd_t  mem_cmd,
  output logic               res_valid,
  output lsu_pkg::lsu_resp_t res
);
  import lsu_pkg::*;

  logic        is_store;
  logic [1:0]  offset;      // byte offset inside the word
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  word_t       rd_data_next;

  // take the head only if the response side can absorb it
  assign pop = head_valid & out_space;

  assign offset   = head.addr[1:0];
  assign is_store = head.op inside {op_sb, op_sh, op_sw};

  // memory command, straight from the head request
  always_comb begin
    mem_cmd.addr  = {head.addr[31:2], 2'b00};
    mem_cmd.wstrb = '0;
    mem_cmd.wdata = head.wdata;
    case (head.op)
      op_sw: begin
        mem_cmd.wstrb = 4'b1111;
      end
      op_sh: begin
        // lane pair picked by address bit 1
        mem_cmd.wstrb = head.addr[1] ? 4'b1100 : 4'b0011;
        mem_cmd.wdata = {2{head.wdata[15:0]}};
      end
      op_sb: begin
        mem_cmd.wstrb = strb_t'(4'b0001 << offset);
        mem_cmd.wdata = {4{head.wdata[7:0]}};
      end
      default: begin
        mem_cmd.wstrb = '0;  // loads and pass-through only read
      end
    endcase
    if (!pop)
      mem_cmd.wstrb = '0;  // no write unless the request leaves the buffer
  end

  // lane selection, misaligned low bits are ignored
  assign byte_sel = mem_rdata[8*offset +: 8];
  assign half_sel = head.addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (head.op)
      op_lb:   rd_data_next = {{24{byte_sel[7]}}, byte_sel};
      op_lbu:  rd_data_next = {24'b0, byte_sel};
      op_lh:   rd_data_next = {{16{half_sel[15]}}, half_sel};
      op_lhu:  rd_data_next = {16'b0, half_sel};
      op_lw:   rd_data_next = mem_rdata;
      op_none: rd_data_next = head.alu_result;
      default: rd_data_next = '0;  // stores write no register
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      res_valid <= 1'b0;
    else
      res_valid <= pop;
  end

  // registered result, one cycle behind the pop
  always_ff @(posedge clk) begin
    if (pop) begin
      res.rd      <= head.rd;
      res.rd_we   <= !is_store;
      res.rd_data <= rd_data_next;
    end
  end

  // byte, halfword and word patterns only
  wstrb_legal: assert property (
    @(posedge clk) disable iff (reset)
    mem_cmd.wstrb inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                          4'b1000, 4'b0011, 4'b1100, 4'b1111}
  ) else $error("illegal write strobe %b", mem_cmd.wstrb);

endmodule

// ==== lsu_data_mem.sv ====
module lsu_data_mem #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic              clk,
  input  lsu_pkg::mem_cmd_t mem_cmd,
  output lsu_pkg::word_t    mem_rdata
);
  import lsu_pkg::*;

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  typedef logic [IDX_W-1:0] word_idx_t;

  word_t     mem [MEM_WORDS];  // contents survive reset
  word_idx_t idx;

  // word index, wraps around the array size
  assign idx = word_idx_t'(mem_cmd.addr[31:2] % MEM_WORDS);

  // byte-lane write on the edge
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (mem_cmd.wstrb[i])
        mem[idx][8*i +: 8] <= mem_cmd.wdata[8*i +: 8];
    end
  end

  assign mem_rdata = mem[idx];  // combinational read

endmodule

// ==== lsu_resp_buffer.sv ====
module lsu_resp_buffer #(
  parameter int unsigned DEPTH   = 4,
  parameter int unsigned CREDITS = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               res_valid,
  input  lsu_pkg::lsu_resp_t res,
  input  logic               resp_credit,
  output logic               out_space,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp
);
  import lsu_pkg::*;
  import lsu_flow_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  lsu_resp_t entries [DEPTH];
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  credit_t   count;
  credit_t   credits;  // responses writeback can still take
  logic      send;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? ptr_t'(0) : ptr_t'(p + 1'b1);
  endfunction

  // two free slots needed, one for the accessor register
  if (DEPTH < 2 || DEPTH > max_credits || CREDITS > max_credits) begin : g_param_check
    $error("response buffer depth %0d or credits %0d out of range", DEPTH, CREDITS);
  end

  assign send       = (count != '0) && (credits != '0);
  assign resp_valid = send;
  assign resp       = entries[rd_ptr];
  assign out_space  = (int'(count) + 2) <= DEPTH;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= credit_t'(CREDITS);
    end else begin
      if (res_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (send)
        rd_ptr <= next_ptr(rd_ptr);
      case ({res_valid, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({resp_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;  // spend and return cancel out
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid)
      entries[wr_ptr] <= res;
  end

  // writeback never returns more than it granted
  credit_bound: assert property (
    @(posedge clk) disable iff (reset)
    credits <= CREDITS
  ) else $error("response credits above grant: %0d", credits);

  // out_space must have held back the accessor in time
  resp_no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    res_valid |-> (count < DEPTH)
  ) else $error("response written into a full buffer");

endmodule

// ==== lsu_top.sv ====
module lsu_top #(
  parameter int unsigned RX_DEPTH   = 4,
  parameter int unsigned TX_DEPTH   = 4,
  parameter int unsigned TX_CREDITS = 2,
  parameter int unsigned MEM_WORDS  = 256
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_valid,
  input  lsu_pkg::lsu_req_t  req,
  input  logic               resp_credit,
  output logic               req_credit,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp
);
  import lsu_pkg::*;

  lsu_req_t  head;
  logic      head_valid;
  logic      pop;
  logic      out_space;
  mem_cmd_t  mem_cmd;
  word_t     mem_rdata;
  logic      res_valid;
  lsu_resp_t res;

  // input side, credits go back to execute
  lsu_req_buffer #(
    .DEPTH (RX_DEPTH)
  ) req_buffer_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .pop        (pop),
    .head       (head),
    .head_valid (head_valid),
    .req_credit (req_credit)
  );

  lsu_accessor accessor_i (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .head_valid (head_valid),
    .out_space  (out_space),
    .mem_rdata  (mem_rdata),
    .pop        (pop),
    .mem_cmd    (mem_cmd),
    .res_valid  (res_valid),
    .res        (res)
  );

  lsu_data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) data_mem_i (
    .clk       (clk),
    .mem_cmd   (mem_cmd),
    .mem_rdata (mem_rdata)
  );

  // output side, spends writeback credits
  lsu_resp_buffer #(
    .DEPTH   (TX_DEPTH),
    .CREDITS (TX_CREDITS)
  ) resp_buffer_i (
    .clk         (clk),
    .reset       (reset),
    .res_valid   (res_valid),
    .res         (res),
    .resp_credit (resp_credit),
    .out_space   (out_space),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

endmodule

// ==== tb_lsu.sv ====
module tb_lsu;
  import lsu_pkg::*;

  localparam int RX_DEPTH   = 4;  // matches the lsu_top default
  localparam int TX_CREDITS = 2;
  localparam int HOLD_CYCLES = 30;  // writeback stall during the flood

  // one table row, stimulus plus expected response
  typedef struct packed {
    mem_op_e  op;
    addr_t    addr;
    word_t    wdata;
    reg_idx_t rd;
    word_t    alu;
    logic     exp_we;
    word_t    exp_data;
  } row_t;

  logic      clk;
  logic      reset;
  logic      req_valid;
  lsu_req_t  req;
  logic      resp_credit;
  logic      req_credit;
  logic      resp_valid;
  lsu_resp_t resp;

  row_t   row_q[$];
  logic   table_ready = 1'b0;
  int     hold_index = -1;  // response whose credit comes back late
  int     sent_count = 0;
  int     req_credit_count = 0;
  int     resp_count = 0;
  int     credit_count = 0;
  int     value_errors = 0;
  int     protocol_errors = 0;
  integer seed = 32'hda72_4dc3;

  lsu_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .resp_credit (resp_credit),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  always #4 clk = ~clk;

  task automatic add_row(input mem_op_e op, input addr_t addr, input word_t wdata,
                         input word_t alu, input logic exp_we, input word_t exp_data);
    row_t r;
    r.op       = op;
    r.addr     = addr;
    r.wdata    = wdata;
    r.rd       = reg_idx_t'(row_q.size() % 31 + 1);  // never x0
    r.alu      = alu;
    r.exp_we   = exp_we;
    r.exp_data = exp_data;
    row_q.push_back(r);
  endtask

  task automatic add_store(input mem_op_e op, input addr_t addr, input word_t wdata);
    add_row(op, addr, wdata, 32'h0, 1'b0, 32'h0);
  endtask

  task automatic add_load(input mem_op_e op, input addr_t addr, input word_t exp_data);
    add_row(op, addr, 32'hffff_ffff, 32'h0, 1'b1, exp_data);
  endtask

  task automatic add_pass(input word_t alu);
    add_row(op_none, 32'h0, 32'h0, alu, 1'b1, alu);
  endtask

  task automatic build_table();
    add_store(op_sw, 32'h100, 32'h1122_3344);
    add_load(op_lw, 32'h100, 32'h1122_3344);
    add_pass(32'hcafe_f00d);
    add_store(op_sw, 32'h000, 32'h0bad_f00d);
    add_load(op_lw, 32'h400, 32'h0bad_f00d);  // wraps onto word 0
    // byte merge, upper bits of wdata must be ignored
    add_store(op_sw, 32'h104, 32'h0);
    add_store(op_sb, 32'h104, 32'hdead_be81);
    add_store(op_sb, 32'h105, 32'hdead_be7f);
    add_store(op_sb, 32'h106, 32'h1234_56c3);
    add_store(op_sb, 32'h107, 32'h1234_563c);
    add_load(op_lw, 32'h104, 32'h3cc3_7f81);
    // halfword merge over all ones
    add_store(op_sw, 32'h108, 32'hffff_ffff);
    add_store(op_sh, 32'h108, 32'h1234_8001);
    add_load(op_lw, 32'h108, 32'hffff_8001);
    add_store(op_sh, 32'h10a, 32'habcd_7ffe);
    add_load(op_lw, 32'h108, 32'h7ffe_8001);
    // byte loads at every offset
    add_load(op_lb,  32'h104, 32'hffff_ff81);
    add_load(op_lbu, 32'h104, 32'h0000_0081);
    add_load(op_lb,  32'h105, 32'h0000_007f);
    add_load(op_lbu, 32'h105, 32'h0000_007f);
    add_load(op_lb,  32'h106, 32'hffff_ffc3);
    add_load(op_lbu, 32'h106, 32'h0000_00c3);
    add_load(op_lb,  32'h107, 32'h0000_003c);
    add_load(op_lbu, 32'h107, 32'h0000_003c);
    // halfword loads, odd addresses drop bit 0
    add_load(op_lh,  32'h104, 32'h0000_7f81);
    add_load(op_lhu, 32'h106, 32'h0000_3cc3);
    add_load(op_lh,  32'h108, 32'hffff_8001);
    add_load(op_lhu, 32'h108, 32'h0000_8001);
    add_load(op_lh,  32'h10a, 32'h0000_7ffe);
    add_load(op_lhu, 32'h10b, 32'h0000_7ffe);
    add_load(op_lh,  32'h109, 32'hffff_8001);
    add_load(op_lw,  32'h106, 32'h3cc3_7f81);
    // back-to-back flood while writeback stalls
    hold_index = row_q.size();
    for (int i = 0; i < 12; i++)
      add_pass(32'h1000_0000 + i * 32'h0101_0101);
  endtask

  task automatic check_response(input lsu_resp_t got, input int idx);
    row_t r;
    r = row_q[idx];
    if (got.rd !== r.rd) begin
      $display("FAILED t=%0t row %0d rd expected %0d got %0d", $time, idx, r.rd, got.rd);
      value_errors++;
    end
    if (got.rd_we !== r.exp_we) begin
      $display("FAILED t=%0t row %0d rd_we expected %b got %b",
               $time, idx, r.exp_we, got.rd_we);
      value_errors++;
    end
    if (r.exp_we && got.rd_data !== r.exp_data) begin
      $display("FAILED t=%0t row %0d rd_data expected %h got %h",
               $time, idx, r.exp_data, got.rd_data);
      value_errors++;
    end
  endtask

  // sample outputs mid-cycle, away from the edges
  always @(negedge clk) begin
    if (!reset) begin
      if (req_credit) begin
        req_credit_count++;
        if (req_credit_count > sent_count) begin
          $display("more request credits returned than requests were sent at t=%0t", $time);
          protocol_errors++;
        end
      end
      if (resp_valid) begin
        if (resp_count >= row_q.size()) begin
          $display("response at t=%0t arrived after all table rows were answered", $time);
          protocol_errors++;
        end else begin
          check_response(resp, resp_count);
        end
        resp_count++;
      end
      if (resp_count - credit_count > TX_CREDITS) begin
        $display("responses sent beyond the writeback credits at t=%0t", $time);
        protocol_errors++;
      end
    end
  end

  // writeback side, one credit per response after a random delay
  initial begin
    int unsigned delay;
    resp_credit = 1'b0;
    forever begin
      @(posedge clk);
      if (credit_count < resp_count) begin
        delay = $unsigned($random(seed)) % 4;
        if (credit_count == hold_index)
          delay = delay + HOLD_CYCLES;
        repeat (delay) @(posedge clk);
        #1 resp_credit = 1'b1;
        @(posedge clk);
        #1 resp_credit = 1'b0;
        credit_count++;
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (40 * row_q.size() + 200) @(posedge clk);
    $display("timeout: only %0d of %0d responses arrived", resp_count, row_q.size());
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    row_t r;
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    build_table();
    table_ready = 1'b1;

    repeat (5) @(posedge clk);
    #1 reset = 1'b0;

    // idle outputs before the first request
    repeat (3) begin
      @(negedge clk);
      if (resp_valid || req_credit) begin
        $display("resp_valid or req_credit high before any request at t=%0t", $time);
        protocol_errors++;
      end
    end
    @(posedge clk);
    #1;

    for (int i = 0; i < row_q.size(); i++) begin
      while (sent_count - req_credit_count >= RX_DEPTH) begin
        @(posedge clk);  // out of credits, wait for one back
        #1;
      end
      r = row_q[i];
      req.op         = r.op;
      req.addr       = r.addr;
      req.wdata      = r.wdata;
      req.rd         = r.rd;
      req.alu_result = r.alu;
      req_valid      = 1'b1;
      sent_count++;
      @(posedge clk);
      #1 req_valid = 1'b0;
    end

    wait (resp_count == row_q.size());
    repeat (4) @(negedge clk);
    if (req_credit_count != sent_count) begin
      $display("request credits returned %0d, requests sent %0d", req_credit_count, sent_count);
      protocol_errors++;
    end
    if (resp_count != row_q.size()) begin
      $display("responses received %0d, table rows %0d", resp_count, row_q.size());
      protocol_errors++;
    end

    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
lsu_pkg.sv
lsu_flow_pkg.sv
lsu_req_buffer.sv
lsu_accessor.sv
lsu_data_mem.sv
lsu_resp_buffer.sv
lsu_top.sv
tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_flow_pkg.sv
  - lsu_req_buffer.sv
  - lsu_accessor.sv
  - lsu_data_mem.sv
  - lsu_resp_buffer.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu.sv
